// File: design/vreg_defs.svh
// Width and slot-count macros for the vector register entry
// Instruction id, register number and one-hot vector widths
// Dispatch and retire slot counts

`ifndef VREG_DEFS_SVH
`define VREG_DEFS_SVH

// Field widths
`define VREG_IID_W      7
`define VREG_ARCH_W     5
`define VREG_PHYS_W     6

// Slot counts
`define VREG_DISP_SLOTS 4
`define VREG_RET_SLOTS  3

// Register file sizes, also the one-hot vector widths
`define VREG_ARCH_NUM   32
`define VREG_PHYS_NUM   64

`endif

// File: design/vreg_data_pkg.sv
// Data types of the vector register entry
// Id and register number words, one-hot vectors
// Dispatch slot, retire slot and stored entry structs

`include "vreg_defs.svh"

package vreg_data_pkg;

  typedef logic [`VREG_IID_W-1:0]    iid_t;
  typedef logic [`VREG_ARCH_W-1:0]   arch_reg_t;
  typedef logic [`VREG_PHYS_W-1:0]   phys_reg_t;

  // Recovery and release vectors
  typedef logic [`VREG_ARCH_NUM-1:0] arch_onehot_t;
  typedef logic [`VREG_PHYS_NUM-1:0] phys_onehot_t;

  // One dispatch slot from the decode stage
  typedef struct packed {
    iid_t      iid;
    arch_reg_t dstv_reg;
    phys_reg_t rel_vreg;
  } disp_slot_t;

  // One retire slot from the reorder buffer
  typedef struct packed {
    logic      updt_vld;
    iid_t      updt_iid;
    logic      retire_vld;
  } retire_slot_t;

  // Allocation data held by the entry
  typedef struct packed {
    iid_t      iid;
    arch_reg_t dstv_reg;
    phys_reg_t rel_vreg;
  } entry_info_t;

endpackage

// File: design/vreg_fsm_pkg.sv
// State encodings of the vector register entry
// Lifecycle FSM (one-hot) and write-back FSM

package vreg_fsm_pkg;

  // Lifecycle of the physical register
  //   DEALLOC  released and written back, free for a new producer
  //   WF_ALLOC picked by the allocator, waiting for the create strobe
  //   ALLOC    owned by an in-flight producer
  //   RETIRE   producer retired, register not yet released
  //   RELEASE  released, waiting for write-back
  typedef enum logic [4:0] {
    DEALLOC  = 5'b00001,
    WF_ALLOC = 5'b00010,
    ALLOC    = 5'b00100,
    RETIRE   = 5'b01000,
    RELEASE  = 5'b10000
  } lifecycle_e;

  // Write-back status of the register value
  typedef enum logic {
    IDLE = 1'b0,
    WB   = 1'b1
  } wb_e;

endpackage

// File: design/vreg_alloc_info.sv
// Allocation information register of the vector register entry
// One-hot dispatch slot select
// Stored iid, destination and replaced physical register

`timescale 1ns/1ps

`include "vreg_defs.svh"

module vreg_alloc_info (
  input  logic                        sm_clk,
  input  logic                        cpurst_b,
  input  logic                        sync_reset,
  input  vreg_data_pkg::arch_reg_t    reset_dstv_reg,
  input  logic [`VREG_DISP_SLOTS-1:0] create_sel,
  input  vreg_data_pkg::disp_slot_t   disp [`VREG_DISP_SLOTS],
  output logic                        create_vld,
  output vreg_data_pkg::entry_info_t  info
);

  vreg_data_pkg::disp_slot_t create_slot;

  //----------------------------------------
  // Create slot select
  //----------------------------------------
  assign create_vld = |create_sel;

  // Strobe is one-hot, so at most one slot matches
  always_comb begin
    create_slot = '0;
    for (int i = 0; i < `VREG_DISP_SLOTS; i++) begin
      if (create_sel[i]) begin
        create_slot = disp[i];
      end
    end
  end

  //----------------------------------------
  // Information register
  //----------------------------------------
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      info <= '0;
    end else if (sync_reset) begin
      // Entry maps the reset architectural register
      info.iid      <= '0;
      info.dstv_reg <= reset_dstv_reg;
      info.rel_vreg <= '0;
    end else if (create_vld) begin
      info.iid      <= create_slot.iid;
      info.dstv_reg <= create_slot.dstv_reg;
      info.rel_vreg <= create_slot.rel_vreg;
    end
  end

endmodule

// File: design/vreg_state_track.sv
// Lifecycle and write-back state tracking of the vector register entry
// Five-state one-hot lifecycle FSM
// Two-state write-back FSM with dealloc masking
// Dealloc and alloc/release state summaries

`timescale 1ns/1ps

module vreg_state_track (
  input  logic                     sm_clk,
  input  logic                     cpurst_b,
  input  logic                     sync_reset,
  input  logic                     reset_mapped,
  input  logic                     flush,
  input  logic                     async_flush,
  input  logic                     dealloc_vld,
  input  logic                     dealloc_mask,
  input  logic                     release_vld,
  input  logic                     wb_vld,
  input  logic                     create_vld,
  input  logic                     retire_vld,
  output vreg_fsm_pkg::lifecycle_e lc_state,
  output vreg_fsm_pkg::wb_e        wb_state,
  output logic                     cur_state_dealloc,
  output logic                     cur_state_alloc_release
);

  vreg_fsm_pkg::lifecycle_e lc_next;
  vreg_fsm_pkg::lifecycle_e lc_reset;
  vreg_fsm_pkg::wb_e        wb_next;
  vreg_fsm_pkg::wb_e        wb_reset;
  logic                     wb_masked;

  //----------------------------------------
  // Lifecycle FSM
  //----------------------------------------
  assign lc_reset = reset_mapped ? vreg_fsm_pkg::RETIRE : vreg_fsm_pkg::DEALLOC;

  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      lc_state <= vreg_fsm_pkg::DEALLOC;
    end else if (sync_reset) begin
      lc_state <= lc_reset;
    end else begin
      lc_state <= lc_next;
    end
  end

  always_comb begin
    lc_next = lc_state;
    case (lc_state)
      vreg_fsm_pkg::DEALLOC: begin
        if (dealloc_vld && !flush) begin
          lc_next = vreg_fsm_pkg::WF_ALLOC;
        end
      end
      vreg_fsm_pkg::WF_ALLOC: begin
        if (flush) begin
          lc_next = vreg_fsm_pkg::DEALLOC;
        end else if (create_vld) begin
          lc_next = vreg_fsm_pkg::ALLOC;
        end
      end
      vreg_fsm_pkg::ALLOC: begin
        if (flush) begin
          lc_next = vreg_fsm_pkg::DEALLOC;
        end else if (release_vld && wb_masked) begin
          lc_next = vreg_fsm_pkg::DEALLOC;
        end else if (release_vld) begin
          lc_next = vreg_fsm_pkg::RELEASE;
        end else if (retire_vld) begin
          lc_next = vreg_fsm_pkg::RETIRE;
        end
      end
      vreg_fsm_pkg::RETIRE: begin
        if (release_vld && wb_masked) begin
          lc_next = vreg_fsm_pkg::DEALLOC;
        end else if (release_vld) begin
          lc_next = vreg_fsm_pkg::RELEASE;
        end
      end
      vreg_fsm_pkg::RELEASE: begin
        // Free once the value has landed
        if (wb_masked) begin
          lc_next = vreg_fsm_pkg::DEALLOC;
        end
      end
      default: lc_next = vreg_fsm_pkg::DEALLOC;
    endcase
  end

  //----------------------------------------
  // Write-back FSM
  //----------------------------------------
  assign wb_reset = reset_mapped ? vreg_fsm_pkg::WB : vreg_fsm_pkg::IDLE;

  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      wb_state <= vreg_fsm_pkg::IDLE;
    end else if (async_flush) begin
      wb_state <= vreg_fsm_pkg::WB;
    end else if (sync_reset) begin
      wb_state <= wb_reset;
    end else if (create_vld) begin
      // New producer, value not written yet
      wb_state <= vreg_fsm_pkg::IDLE;
    end else begin
      wb_state <= wb_next;
    end
  end

  always_comb begin
    wb_next = wb_state;
    case (wb_state)
      vreg_fsm_pkg::IDLE: begin
        if (wb_vld) begin
          wb_next = vreg_fsm_pkg::WB;
        end
      end
      vreg_fsm_pkg::WB: begin
        if (cur_state_dealloc) begin
          wb_next = vreg_fsm_pkg::IDLE;
        end
      end
      default: wb_next = vreg_fsm_pkg::IDLE;
    endcase
  end

  // Write-back seen by dealloc, held off by the mask
  assign wb_masked = (wb_state == vreg_fsm_pkg::WB) && !dealloc_mask;

  // State summaries
  assign cur_state_dealloc       = (lc_state == vreg_fsm_pkg::DEALLOC);
  assign cur_state_alloc_release = (lc_state == vreg_fsm_pkg::ALLOC)
                                || (lc_state == vreg_fsm_pkg::RELEASE);

endmodule

// File: design/vreg_retire_release.sv
// Retire match and release logic of the vector register entry
// Early iid match registers, one per retire slot
// Release vector, recovery vector and retired write-back flag

`timescale 1ns/1ps

`include "vreg_defs.svh"

module vreg_retire_release (
  input  logic                         sm_clk,
  input  logic                         cpurst_b,
  input  logic                         sync_reset,
  input  vreg_data_pkg::retire_slot_t  retire [`VREG_RET_SLOTS],
  input  vreg_data_pkg::entry_info_t   info,
  input  vreg_fsm_pkg::lifecycle_e     lc_state,
  input  vreg_fsm_pkg::wb_e            wb_state,
  output logic                         retire_vld,
  output vreg_data_pkg::phys_onehot_t  rel_vreg_expand,
  output vreg_data_pkg::arch_onehot_t  dreg,
  output logic                         retired_released_wb
);

  logic [`VREG_RET_SLOTS-1:0]  iid_match;
  logic [`VREG_RET_SLOTS-1:0]  slot_retire;
  logic                        lc_alloc;
  logic                        lc_retire;
  logic                        lc_release;
  logic                        rel_retire_vld;
  vreg_data_pkg::phys_onehot_t rel_onehot;
  vreg_data_pkg::arch_onehot_t dstv_onehot;

  assign lc_alloc   = (lc_state == vreg_fsm_pkg::ALLOC);
  assign lc_retire  = (lc_state == vreg_fsm_pkg::RETIRE);
  assign lc_release = (lc_state == vreg_fsm_pkg::RELEASE);

  //----------------------------------------
  // Early iid match
  //----------------------------------------
  // Compare one cycle before the retire strobe to keep it off the
  // retire path
  always_ff @(posedge sm_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      iid_match <= '0;
    end else if (sync_reset) begin
      iid_match <= '0;
    end else begin
      for (int i = 0; i < `VREG_RET_SLOTS; i++) begin
        if (retire[i].updt_vld) begin
          iid_match[i] <= lc_alloc && (info.iid == retire[i].updt_iid);
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `VREG_RET_SLOTS; i++) begin
      slot_retire[i] = retire[i].retire_vld && iid_match[i];
    end
  end

  assign retire_vld = |slot_retire;

  //----------------------------------------
  // Release and recovery vectors
  //----------------------------------------
  assign rel_onehot  = vreg_data_pkg::phys_onehot_t'(1) << info.rel_vreg;
  assign dstv_onehot = vreg_data_pkg::arch_onehot_t'(1) << info.dstv_reg;

  // Match register can hold a stale hit after the entry leaves ALLOC
  assign rel_retire_vld  = lc_alloc && retire_vld;
  assign rel_vreg_expand = rel_retire_vld ? rel_onehot : '0;

  assign dreg = lc_retire ? dstv_onehot : '0;

  // Used by the flush logic in the retiring cycle as well
  assign retired_released_wb = (rel_retire_vld || lc_retire || lc_release)
                             ? (wb_state == vreg_fsm_pkg::WB) : 1'b1;

endmodule

// File: design/vreg_entry.sv
// Top level of one physical vector register entry
// Allocation info register, state tracker, retire and release logic

`timescale 1ns/1ps

`include "vreg_defs.svh"

module vreg_entry (
  input  logic                         sm_clk,
  input  logic                         cpurst_b,
  input  logic                         sync_reset,
  input  logic                         reset_mapped,
  input  vreg_data_pkg::arch_reg_t     reset_dstv_reg,
  input  logic                         flush,
  input  logic                         async_flush,
  input  logic                         dealloc_vld,
  input  logic                         dealloc_mask,
  input  logic                         release_vld,
  input  logic                         wb_vld,
  input  logic [`VREG_DISP_SLOTS-1:0]  create_sel,
  input  vreg_data_pkg::disp_slot_t    disp [`VREG_DISP_SLOTS],
  input  vreg_data_pkg::retire_slot_t  retire [`VREG_RET_SLOTS],
  output logic                         cur_state_dealloc,
  output logic                         cur_state_alloc_release,
  output vreg_data_pkg::phys_onehot_t  rel_vreg_expand,
  output vreg_data_pkg::arch_onehot_t  dreg,
  output logic                         retired_released_wb
);

  logic                       create_vld;
  logic                       retire_vld;
  vreg_data_pkg::entry_info_t info;
  vreg_fsm_pkg::lifecycle_e   lc_state;
  vreg_fsm_pkg::wb_e          wb_state;

  // Allocation data
  vreg_alloc_info u_alloc_info (
    .sm_clk         (sm_clk),
    .cpurst_b       (cpurst_b),
    .sync_reset     (sync_reset),
    .reset_dstv_reg (reset_dstv_reg),
    .create_sel     (create_sel),
    .disp           (disp),
    .create_vld     (create_vld),
    .info           (info)
  );

  // Lifecycle and write-back
  vreg_state_track u_state_track (
    .sm_clk                  (sm_clk),
    .cpurst_b                (cpurst_b),
    .sync_reset              (sync_reset),
    .reset_mapped            (reset_mapped),
    .flush                   (flush),
    .async_flush             (async_flush),
    .dealloc_vld             (dealloc_vld),
    .dealloc_mask            (dealloc_mask),
    .release_vld             (release_vld),
    .wb_vld                  (wb_vld),
    .create_vld              (create_vld),
    .retire_vld              (retire_vld),
    .lc_state                (lc_state),
    .wb_state                (wb_state),
    .cur_state_dealloc       (cur_state_dealloc),
    .cur_state_alloc_release (cur_state_alloc_release)
  );

  // Retire match and release
  vreg_retire_release u_retire_release (
    .sm_clk              (sm_clk),
    .cpurst_b            (cpurst_b),
    .sync_reset          (sync_reset),
    .retire              (retire),
    .info                (info),
    .lc_state            (lc_state),
    .wb_state            (wb_state),
    .retire_vld          (retire_vld),
    .rel_vreg_expand     (rel_vreg_expand),
    .dreg                (dreg),
    .retired_released_wb (retired_released_wb)
  );

endmodule

// File: tb/vreg_entry_assert.sv
// Concurrent assertions on the vector register entry
// State summary exclusion, one-hot output vectors, flush to dealloc
// Bound into every vreg_entry instance

`timescale 1ns/1ps

module vreg_entry_assert (
  input logic                        sm_clk,
  input logic                        cpurst_b,
  input logic                        flush,
  input logic                        sync_reset,
  input vreg_fsm_pkg::lifecycle_e    lc_state,
  input logic                        cur_state_dealloc,
  input logic                        cur_state_alloc_release,
  input vreg_data_pkg::phys_onehot_t rel_vreg_expand,
  input vreg_data_pkg::arch_onehot_t dreg
);

  // Read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  summary_exclusive: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    !(cur_state_dealloc && cur_state_alloc_release))
    else begin
      $error("dealloc and alloc/release summaries both high");
      fail_cnt++;
    end

  rel_vector_onehot: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    $onehot0(rel_vreg_expand))
    else begin
      $error("rel_vreg_expand has more than one bit set");
      fail_cnt++;
    end

  dreg_onehot: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    $onehot0(dreg))
    else begin
      $error("dreg has more than one bit set");
      fail_cnt++;
    end

  // RETIRE and RELEASE ignore flush
  flush_to_dealloc: assert property (@(posedge sm_clk) disable iff (!cpurst_b)
    flush && !sync_reset && (lc_state != vreg_fsm_pkg::RETIRE)
      && (lc_state != vreg_fsm_pkg::RELEASE) |=> cur_state_dealloc)
    else begin
      $error("entry not in dealloc one cycle after flush");
      fail_cnt++;
    end

endmodule

bind vreg_entry vreg_entry_assert u_assert (
  .sm_clk                  (sm_clk),
  .cpurst_b                (cpurst_b),
  .flush                   (flush),
  .sync_reset              (sync_reset),
  .lc_state                (lc_state),
  .cur_state_dealloc       (cur_state_dealloc),
  .cur_state_alloc_release (cur_state_alloc_release),
  .rel_vreg_expand         (rel_vreg_expand),
  .dreg                    (dreg)
);

// File: tb/tb_vreg_entry.sv
// Testbench of the vector register entry
// Clock, reset, directed stimulus over three entry lifecycles
// Value checks, per-test report, cycle limit

`timescale 1ns/1ps

`include "vreg_defs.svh"

module tb_vreg_entry;

  // Directed tests take about 45 cycles
  localparam int MAX_CYCLES = 200;

  logic                         sm_clk;
  logic                         cpurst_b;
  logic                         sync_reset;
  logic                         reset_mapped;
  vreg_data_pkg::arch_reg_t     reset_dstv_reg;
  logic                         flush;
  logic                         async_flush;
  logic                         dealloc_vld;
  logic                         dealloc_mask;
  logic                         release_vld;
  logic                         wb_vld;
  logic [`VREG_DISP_SLOTS-1:0]  create_sel;
  vreg_data_pkg::disp_slot_t    disp [`VREG_DISP_SLOTS];
  vreg_data_pkg::retire_slot_t  retire [`VREG_RET_SLOTS];
  logic                         cur_state_dealloc;
  logic                         cur_state_alloc_release;
  vreg_data_pkg::phys_onehot_t  rel_vreg_expand;
  vreg_data_pkg::arch_onehot_t  dreg;
  logic                         retired_released_wb;

  vreg_data_pkg::iid_t      exp_iid;
  vreg_data_pkg::arch_reg_t exp_dstv;
  vreg_data_pkg::phys_reg_t exp_rel;
  int                       errors = 0;
  int                       errors_before = 0;
  int                       tests = 0;
  int                       failed = 0;
  int                       cycles = 0;

  vreg_entry dut (.*);

  initial begin
    sm_clk = 1'b0;
    forever #2 sm_clk = ~sm_clk;
  end

  always @(posedge sm_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    assert (got === exp) else begin
      $display("Fail %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      failed++;
      $display("Test %s: failed", name);
    end
    errors_before = errors;
  endtask

  // DEALLOC to WF_ALLOC to ALLOC from a random dispatch slot
  task automatic allocate_entry();
    logic [1:0] dslot;
    @(posedge sm_clk);
    dealloc_vld <= 1'b1;
    for (int i = 0; i < `VREG_DISP_SLOTS; i++) begin
      disp[i].iid      <= vreg_data_pkg::iid_t'($urandom);
      disp[i].dstv_reg <= vreg_data_pkg::arch_reg_t'($urandom);
      disp[i].rel_vreg <= vreg_data_pkg::phys_reg_t'($urandom);
    end
    @(posedge sm_clk);
    dslot = 2'($urandom);
    dealloc_vld <= 1'b0;
    create_sel  <= 4'b0001 << dslot;
    exp_iid  = disp[dslot].iid;
    exp_dstv = disp[dslot].dstv_reg;
    exp_rel  = disp[dslot].rel_vreg;
    @(posedge sm_clk);
    create_sel <= '0;
    @(negedge sm_clk);
  endtask

  // Update in one cycle, retire strobe in the next
  task automatic retire_attempt(input logic [1:0] rs, input vreg_data_pkg::iid_t id,
                                output vreg_data_pkg::phys_onehot_t seen_rel);
    @(posedge sm_clk);
    retire[rs].updt_vld <= 1'b1;
    retire[rs].updt_iid <= id;
    @(posedge sm_clk);
    retire[rs].updt_vld   <= 1'b0;
    retire[rs].retire_vld <= 1'b1;
    @(negedge sm_clk);
    seen_rel = rel_vreg_expand;
    @(posedge sm_clk);
    retire[rs].retire_vld <= 1'b0;
    @(negedge sm_clk);
  endtask

  initial begin
    vreg_data_pkg::phys_onehot_t seen_rel;
    vreg_data_pkg::arch_reg_t    rst_dstv;
    logic [1:0]                  rslot;
    logic [1:0]                  nslot;
    void'($urandom(34));
    cpurst_b       = 1'b0;
    sync_reset     = 1'b0;
    reset_mapped   = 1'b0;
    reset_dstv_reg = '0;
    flush          = 1'b0;
    async_flush    = 1'b0;
    dealloc_vld    = 1'b0;
    dealloc_mask   = 1'b0;
    release_vld    = 1'b0;
    wb_vld         = 1'b0;
    create_sel     = '0;
    for (int i = 0; i < `VREG_DISP_SLOTS; i++) begin
      disp[i] = '0;
    end
    for (int i = 0; i < `VREG_RET_SLOTS; i++) begin
      retire[i] = '0;
    end
    repeat (2) @(posedge sm_clk);
    cpurst_b <= 1'b1;
    @(negedge sm_clk);

    check_value(64'(cur_state_dealloc), 64'd1, "cur_state_dealloc after reset");
    check_value(64'(cur_state_alloc_release), 64'd0, "alloc_release after reset");
    check_value(64'(dreg), 64'd0, "dreg after reset");
    check_value(rel_vreg_expand, 64'd0, "rel_vreg_expand after reset");
    finish_test("reset");

    allocate_entry();
    check_value(64'(cur_state_alloc_release), 64'd1, "alloc_release after create");
    finish_test("allocate");

    //----------------------------------------
    // Lifecycle 1: retire, release, write-back
    //----------------------------------------
    rslot = 2'($urandom_range(2, 0));
    nslot = (rslot == 2'd2) ? 2'd0 : rslot + 2'd1;
    retire_attempt(nslot, exp_iid ^ vreg_data_pkg::iid_t'(1), seen_rel);
    check_value(seen_rel, 64'd0, "rel_vreg_expand on iid mismatch");
    check_value(64'(cur_state_alloc_release), 64'd1, "alloc_release after mismatch");
    retire_attempt(rslot, exp_iid, seen_rel);
    check_value(seen_rel, 64'd1 << exp_rel, "rel_vreg_expand on retire");
    check_value(64'(dreg), 64'd1 << exp_dstv, "dreg after retire");
    finish_test("retire match");

    check_value(64'(retired_released_wb), 64'd0, "retired_released_wb before write-back");
    @(posedge sm_clk);
    release_vld <= 1'b1;
    @(posedge sm_clk);
    release_vld <= 1'b0;
    @(negedge sm_clk);
    check_value(64'(cur_state_alloc_release), 64'd1, "alloc_release after release");
    @(posedge sm_clk);
    wb_vld <= 1'b1;
    @(posedge sm_clk);
    wb_vld <= 1'b0;
    @(negedge sm_clk);
    check_value(64'(retired_released_wb), 64'd1, "retired_released_wb after wb_vld");
    @(negedge sm_clk);
    check_value(64'(cur_state_dealloc), 64'd1, "dealloc two cycles after wb_vld");
    finish_test("release and write-back");

    //----------------------------------------
    // Lifecycle 2: async flush, dealloc mask
    //----------------------------------------
    allocate_entry();
    retire_attempt(rslot, exp_iid, seen_rel);
    check_value(64'(retired_released_wb), 64'd0, "retired_released_wb in RETIRE");
    @(posedge sm_clk);
    async_flush  <= 1'b1;
    dealloc_mask <= 1'b1;
    @(posedge sm_clk);
    async_flush <= 1'b0;
    @(negedge sm_clk);
    check_value(64'(retired_released_wb), 64'd1, "retired_released_wb after async_flush");
    finish_test("retired write-back flag");

    @(posedge sm_clk);
    release_vld <= 1'b1;
    @(posedge sm_clk);
    release_vld <= 1'b0;
    repeat (2) @(negedge sm_clk);
    check_value(64'(cur_state_alloc_release), 64'd1, "release held by dealloc_mask");
    @(posedge sm_clk);
    dealloc_mask <= 1'b0;
    @(posedge sm_clk);
    @(negedge sm_clk);
    check_value(64'(cur_state_dealloc), 64'd1, "dealloc after mask drops");
    finish_test("dealloc mask");

    //----------------------------------------
    // Lifecycle 3: flush, mapped reset
    //----------------------------------------
    allocate_entry();
    @(posedge sm_clk);
    flush <= 1'b1;
    @(posedge sm_clk);
    flush <= 1'b0;
    @(negedge sm_clk);
    check_value(64'(cur_state_dealloc), 64'd1, "cur_state_dealloc after flush");
    rst_dstv = vreg_data_pkg::arch_reg_t'($urandom);
    @(posedge sm_clk);
    sync_reset     <= 1'b1;
    reset_mapped   <= 1'b1;
    reset_dstv_reg <= rst_dstv;
    @(posedge sm_clk);
    sync_reset   <= 1'b0;
    reset_mapped <= 1'b0;
    @(negedge sm_clk);
    check_value(64'(dreg), 64'd1 << rst_dstv, "dreg after mapped reset");
    check_value(64'(retired_released_wb), 64'd1, "retired_released_wb after mapped reset");
    finish_test("flush and reset");

    errors += int'(dut.u_assert.fail_cnt);
    $display("Tests: %0d, failed: %0d, errors: %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+design
design/vreg_data_pkg.sv
design/vreg_fsm_pkg.sv
design/vreg_alloc_info.sv
design/vreg_state_track.sv
design/vreg_retire_release.sv
design/vreg_entry.sv
tb/vreg_entry_assert.sv
tb/tb_vreg_entry.sv

// File: Makefile
# Verilator build and run of the vector register entry testbench

TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_vreg_entry
FILELIST := compile.f
OBJ_DIR  := obj_dir
PASS_MSG := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
